/* list.f */
verilog/debugPkg.sv
verilog/debugDecoder.sv
verilog/debugCommandPort.sv
verilog/debugBusSequencer.sv
verilog/debugController.sv
verification/wbMemoryModel.sv
verification/debugControllerTb.sv

/* verification/debugControllerTb.sv */
`default_nettype none
`timescale 1ns/1ps

module debugControllerTb import debugPkg::*; ();

localparam int dataWidth = 16;
localparam int addrWidth = 16;
localparam int waitLimit = 100;

logic                 clk;
logic                 rstN;
logic                 cmdValid;
debugOp               cmdOp;
logic [3:0]           cmdArg;
logic [dataWidth-1:0] cmdData;
logic                 cmdReady;
logic                 rspValid;
logic [dataWidth-1:0] rspData;
logic                 rspReady;
logic                 cpuStop;
logic                 regRead;
logic [1:0]           ccReg;
logic [2:0]           pcNext;
logic [dataWidth-1:0] regBData;
logic                 wbCyc;
logic                 wbStb;
logic                 wbWe;
logic [addrWidth-1:0] wbAdr;
logic [dataWidth-1:0] wbDatO;
logic [dataWidth-1:0] wbDatI;
logic                 wbAck;
logic [2:0]           ackDelay;

logic [31:0]          lfsrState;
logic                 bpOn; // random gaps in rspReady.
logic [3:0]           expArg;
logic [addrWidth-1:0] expAddr;
logic [dataWidth-1:0] expWrData;
logic                 expWe;
logic [addrWidth-1:0] shadowAddr;
logic [dataWidth-1:0] shadowMem [logic [addrWidth-1:0]];

debugController #(.dataWidth(dataWidth), .addrWidth(addrWidth)) dut (
	.clk(clk), .rstN(rstN),
	.cmdValid(cmdValid), .cmdOp(cmdOp), .cmdArg(cmdArg), .cmdData(cmdData),
	.cmdReady(cmdReady), .rspValid(rspValid), .rspData(rspData), .rspReady(rspReady),
	.cpuStop(cpuStop), .regRead(regRead), .ccReg(ccReg), .pcNext(pcNext),
	.regBData(regBData),
	.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
	.wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck)
);

wbMemoryModel #(.dataWidth(dataWidth), .addrWidth(addrWidth)) memory (
	.clk(clk), .rstN(rstN), .ackDelay(ackDelay),
	.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
	.wbDatI(wbDatO), .wbDatO(wbDatI), .wbAck(wbAck)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic abortRun(input string msg);
	$display("%s", msg);
	$display("Test FAILED");
	$fatal(1);
endtask

task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] expected);
	abortRun($sformatf("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, expected));
endtask

task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] expected);
	assert (got === expected) else mismatch(name, got, expected);
endtask

// galois lfsr, one step per bit taken.
function automatic logic [31:0] nextRandom(input int width);
	logic [31:0] value;
	int          i;
	value = '0;
	for (i = 0; i < width; i++) begin
		value     = {value[30:0], lfsrState[0]};
		lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
	end
	return value;
endfunction

// power-up contents of the memory model.
function automatic logic [dataWidth-1:0] fillWord(input logic [addrWidth-1:0] addr);
	return dataWidth'(int'(addr) * 40503 + 7);
endfunction

task automatic sendCommand(input logic [2:0] opCode, input logic [3:0] argIn,
	input logic [dataWidth-1:0] dataIn);
	logic [dataWidth-1:0] expected;
	logic [addrWidth-1:0] access;
	logic                 isMem;
	logic                 taken;
	int                   waited;
	isMem  = opCode == opRdMem || opCode == opWrMem;
	access = argIn[0] ? addrWidth'(dataIn) : shadowAddr;
	ackDelay  = 3'(nextRandom(3));
	expArg    = argIn;
	expAddr   = access;
	expWrData = dataIn;
	expWe     = opCode == opWrMem;
	cmdValid  = 1'b1;
	cmdOp     = debugOp'(opCode);
	cmdArg    = argIn;
	cmdData   = dataIn;
	waited    = 0;
	while (!cmdReady) begin
		@(negedge clk);
		waited++;
		if (waited > waitLimit)
			abortRun("command was not accepted before the timeout");
	end
	@(negedge clk); // execute cycle.
	cmdValid = 1'b0;
	regBData = dataWidth'(nextRandom(dataWidth));
	case (opCode)
		opRdReg: expected = regBData;
		opRdMem: expected = shadowMem.exists(access) ? shadowMem[access] : fillWord(access);
		default: expected = dataIn; // everything else echoes the data word.
	endcase
	if (opCode == opWrMem)
		shadowMem[access] = dataIn;
	if (isMem)
		shadowAddr = access + 1'b1;
	taken  = 1'b0;
	waited = 0;
	while (!taken) begin
		@(negedge clk);
		waited++;
		if (waited > waitLimit)
			abortRun("no response arrived before the timeout");
		regBData = dataWidth'(nextRandom(dataWidth));
		if (!isMem && waited == 1)
			checkEqual("rspValid", rspValid, 1'b1);
		if (rspValid) begin
			checkEqual("rspData", rspData, expected);
			checkEqual("cmdReady", cmdReady, 1'b0);
			rspReady = bpOn ? nextRandom(2) == 0 : 1'b1;
			taken    = rspReady;
		end else begin
			rspReady = 1'(nextRandom(1));
		end
	end
	@(negedge clk);
	rspReady = 1'b0;
	checkEqual("rspValid", rspValid, 1'b0); // no second copy.
	checkEqual("cpuStop", cpuStop, opCode != opNone);
endtask

assert property (@(posedge clk) disable iff (!rstN)
	cmdValid && cmdReady |=> ccReg == (cmdOp == opRdCc ? expArg[1:0] : ccRun))
	else mismatch("ccReg", $sampled(ccReg), cmdOp == opRdCc ? expArg[1:0] : ccRun);

assert property (@(posedge clk) disable iff (!rstN)
	cmdValid && cmdReady |=> pcNext == (cmdOp == opRdPc ? expArg[2:0] : pcNextNext))
	else mismatch("pcNext", $sampled(pcNext), cmdOp == opRdPc ? expArg[2:0] : pcNextNext);

assert property (@(posedge clk) disable iff (!rstN)
	cmdValid && cmdReady |=> regRead == (cmdOp == opRdReg))
	else mismatch("regRead", $sampled(regRead), cmdOp == opRdReg);

// outside the execute cycle the cpu sees its running values.
assert property (@(posedge clk) disable iff (!rstN)
	!(cmdValid && cmdReady) |=> ccReg == ccRun && pcNext == pcNextNext && !regRead)
	else abortRun("CPU selector or regRead active outside the execute cycle");

assert property (@(posedge clk) disable iff (!rstN)
	rspValid && !rspReady |=> rspValid && $stable(rspData) && !cmdReady)
	else abortRun("response changed, dropped or overlapped a command under back-pressure");

assert property (@(posedge clk) disable iff (!rstN) wbCyc == wbStb)
	else mismatch("wbStb", $sampled(wbStb), $sampled(wbCyc));

assert property (@(posedge clk) disable iff (!rstN) wbCyc |-> wbAdr == expAddr)
	else mismatch("wbAdr", $sampled(wbAdr), expAddr);

assert property (@(posedge clk) disable iff (!rstN) wbCyc |-> wbWe == expWe)
	else mismatch("wbWe", $sampled(wbWe), expWe);

assert property (@(posedge clk) disable iff (!rstN) wbCyc && wbWe |-> wbDatO == expWrData)
	else mismatch("wbDatO", $sampled(wbDatO), expWrData);

assert property (@(posedge clk) disable iff (!rstN) wbCyc && wbAck |=> !wbCyc)
	else abortRun("bus cycle stayed open after ack");

initial begin
	int                   n;
	logic [dataWidth-1:0] word;
	logic [dataWidth-1:0] base;
	rstN       = 1'b0;
	cmdValid   = 1'b0;
	cmdOp      = opNone;
	cmdArg     = '0;
	cmdData    = '0;
	rspReady   = 1'b0;
	regBData   = '0;
	ackDelay   = '0;
	lfsrState  = 32'h62f2_ce6b;
	bpOn       = 1'b0;
	expArg     = '0;
	expAddr    = '0;
	expWrData  = '0;
	expWe      = 1'b0;
	shadowAddr = '0;
	repeat (3) @(posedge clk);
	@(negedge clk);
	rstN = 1'b1;

	checkEqual("cmdReady", cmdReady, 1'b1);
	checkEqual("cpuStop", cpuStop, 1'b0);
	checkEqual("rspValid", rspValid, 1'b0);
	checkEqual("regRead", regRead, 1'b0);
	checkEqual("wbCyc", wbCyc, 1'b0);

	// loaded address, the word written is the address itself.
	for (n = 0; n < 4; n++) begin
		word = dataWidth'(nextRandom(dataWidth));
		sendCommand(opWrMem, {3'(nextRandom(3)), 1'b1}, word);
		sendCommand(opRdMem, {3'(nextRandom(3)), 1'b1}, word);
	end

	base = dataWidth'(nextRandom(dataWidth));
	sendCommand(opRdMem, 4'b0001, base);
	for (n = 0; n < 6; n++)
		sendCommand(opWrMem, {3'(nextRandom(3)), 1'b0}, dataWidth'(nextRandom(dataWidth)));
	sendCommand(opRdMem, 4'b0001, base);
	for (n = 0; n < 7; n++)
		sendCommand(opRdMem, {3'(nextRandom(3)), 1'b0}, dataWidth'(nextRandom(dataWidth)));

	for (n = 0; n < 4; n++)
		sendCommand(opRdReg, 4'(nextRandom(4)), dataWidth'(nextRandom(dataWidth)));
	for (n = 0; n < 4; n++)
		sendCommand(opRdCc, {2'(nextRandom(2)), 2'(n)}, dataWidth'(nextRandom(dataWidth)));
	for (n = 0; n < 8; n++)
		sendCommand(opRdPc, {1'(nextRandom(1)), 3'(n)}, dataWidth'(nextRandom(dataWidth)));

	// every code halts, then opNone lets the cpu run again.
	for (n = 0; n < 8; n++) begin
		sendCommand(3'(n), 4'(nextRandom(4)), dataWidth'(nextRandom(dataWidth)));
		sendCommand(opNone, 4'(nextRandom(4)), dataWidth'(nextRandom(dataWidth)));
	end

	bpOn = 1'b1;
	for (n = 0; n < 40; n++)
		sendCommand(3'(nextRandom(3)), 4'(nextRandom(4)), dataWidth'(nextRandom(dataWidth)));

	$display("Test OK");
	$finish;
end

endmodule

`default_nettype wire

/* verification/wbMemoryModel.sv */
`default_nettype none
`timescale 1ns/1ps

module wbMemoryModel #(
	parameter int dataWidth = 16,
	parameter int addrWidth = 16
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [2:0]           ackDelay, // wait states before ack.
	input  logic                 wbCyc,
	input  logic                 wbStb,
	input  logic                 wbWe,
	input  logic [addrWidth-1:0] wbAdr,
	input  logic [dataWidth-1:0] wbDatI,
	output logic [dataWidth-1:0] wbDatO,
	output logic                 wbAck
);

logic [dataWidth-1:0] mem [2**addrWidth];
logic [2:0]           waitCount;

initial begin
	int i;
	// odd multiplier, so every address bit shows in the word.
	for (i = 0; i < 2**addrWidth; i++)
		mem[i] = dataWidth'(i * 40503 + 7);
end

assign wbDatO = mem[wbAdr];

always @(posedge clk) begin
	if (!rstN) begin
		wbAck     <= 1'b0;
		waitCount <= '0;
	end else begin
		wbAck <= 1'b0; // single-cycle ack.
		if (wbCyc && wbStb && !wbAck) begin
			if (waitCount >= ackDelay) begin
				wbAck     <= 1'b1;
				waitCount <= '0;
				if (wbWe)
					mem[wbAdr] <= wbDatI;
			end else begin
				waitCount <= waitCount + 1'b1;
			end
		end
	end
end

endmodule

`default_nettype wire

/* verilog/debugBusSequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module debugBusSequencer import debugPkg::*; #(
	parameter int dataWidth = 16,
	parameter int addrWidth = 16
) (
	input  logic                 clk,
	input  logic                 rstN,

	input  logic                 exec,
	input  busSeq                busAction,
	input  logic                 addrLd,
	input  logic                 addrInc,
	input  logic [dataWidth-1:0] data,
	output logic [dataWidth-1:0] memData,
	output logic                 busDone,

	output logic                 wbCyc,
	output logic                 wbStb,
	output logic                 wbWe,
	output logic [addrWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatO,
	input  logic [dataWidth-1:0] wbDatI,
	input  logic                 wbAck
);

logic [addrWidth-1:0] addrReg;
logic                 busStart;
logic                 busEnd;

assign busStart = exec && busAction != busNone;
assign busEnd   = wbCyc && wbAck;
assign wbAdr    = addrReg;

always_ff @(posedge clk) begin
	if (!rstN) begin
		addrReg <= '0;
		wbCyc   <= 1'b0;
		wbStb   <= 1'b0;
		wbWe    <= 1'b0;
		busDone <= 1'b0;
	end else begin
		busDone <= busEnd;
		if (busStart) begin
			if (addrLd)
				addrReg <= addrWidth'(data);
			wbCyc <= 1'b1;
			wbStb <= 1'b1;
			wbWe  <= busAction == busWrite;
		end else if (busEnd) begin
			wbCyc <= 1'b0; // cyc and stb drop together.
			wbStb <= 1'b0;
			wbWe  <= 1'b0;
			if (addrInc)
				addrReg <= addrReg + 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (busStart)
		wbDatO <= data;
	if (busEnd && !wbWe)
		memData <= wbDatI;
end

assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc);

// a cycle waiting for ack keeps its address.
assert property (@(posedge clk) disable iff (!rstN)
	wbCyc && !wbAck |=> wbCyc && $stable(wbAdr));

endmodule

`default_nettype wire

/* verilog/debugCommandPort.sv */
`default_nettype none
`timescale 1ns/1ps

module debugCommandPort import debugPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 rstN,

	input  logic                 cmdValid,
	input  debugOp               cmdOp,
	input  logic [3:0]           cmdArg,
	input  logic [dataWidth-1:0] cmdData,
	output logic                 cmdReady,

	output logic                 rspValid,
	output logic [dataWidth-1:0] rspData,
	input  logic                 rspReady,

	output debugOp               op,
	output logic [3:0]           arg,
	output logic [dataWidth-1:0] data,
	output logic                 exec,

	input  logic                 regRd,
	input  logic [1:0]           ccSel,
	input  logic [2:0]           pcSel,
	input  logic                 stop,
	input  dataSel               dataSelect,
	input  busSeq                busAction,

	output logic                 regRead,
	output logic [1:0]           ccReg,
	output logic [2:0]           pcNext,
	output logic                 cpuStop,
	input  logic [dataWidth-1:0] regBData,

	input  logic [dataWidth-1:0] memData,
	input  logic                 busDone
);

portState             state;
logic [dataWidth-1:0] rspWord;
logic                 rspLoad;

assign cmdReady = state == stIdle;
assign rspValid = state == stRespond;
assign exec     = state == stExec;

// cpu controls only leave their idle values in the execute cycle.
assign regRead = exec & regRd;
assign ccReg   = exec ? ccSel : ccRun;
assign pcNext  = exec ? pcSel : pcNextNext;

always_comb begin
	case (dataSelect)
		selRegB: rspWord = regBData;
		selMem:  rspWord = memData;
		default: rspWord = data;
	endcase
end

assign rspLoad = (exec && busAction == busNone) || (state == stWaitBus && busDone);

always_ff @(posedge clk) begin
	if (!rstN) begin
		state   <= stIdle;
		op      <= opNone;
		cpuStop <= 1'b0;
	end else begin
		case (state)
			stIdle: begin
				if (cmdValid) begin
					state <= stExec;
					op    <= cmdOp;
				end
			end
			stExec: begin
				cpuStop <= stop;
				state   <= (busAction == busNone) ? stRespond : stWaitBus;
			end
			stWaitBus: if (busDone) state <= stRespond;
			stRespond: if (rspReady) state <= stIdle;
			default:   state <= stIdle;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (cmdValid && cmdReady) begin
		arg  <= cmdArg;
		data <= cmdData;
	end
	if (rspLoad)
		rspData <= rspWord; // held until the host takes it.
end

assert property (@(posedge clk) disable iff (!rstN)
	rspValid && !rspReady |=> rspValid && $stable(rspData));

assert property (@(posedge clk) disable iff (!rstN) !(cmdReady && rspValid));

endmodule

`default_nettype wire

/* verilog/debugController.sv */
`default_nettype none
`timescale 1ns/1ps

module debugController import debugPkg::*; #(
	parameter int dataWidth = 16,
	parameter int addrWidth = 16
) (
	input  logic                 clk,
	input  logic                 rstN,

	input  logic                 cmdValid,
	input  debugOp               cmdOp,
	input  logic [3:0]           cmdArg,
	input  logic [dataWidth-1:0] cmdData,
	output logic                 cmdReady,
	output logic                 rspValid,
	output logic [dataWidth-1:0] rspData,
	input  logic                 rspReady,

	output logic                 cpuStop,
	output logic                 regRead,
	output logic [1:0]           ccReg,
	output logic [2:0]           pcNext,
	input  logic [dataWidth-1:0] regBData,

	output logic                 wbCyc,
	output logic                 wbStb,
	output logic                 wbWe,
	output logic [addrWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatO,
	input  logic [dataWidth-1:0] wbDatI,
	input  logic                 wbAck
);

debugOp               op;
logic [3:0]           arg;
logic [dataWidth-1:0] data;
logic                 exec;
logic                 addrInc;
logic                 addrLd;
dataSel               dataSelect;
busSeq                busAction;
logic                 regRd;
logic [1:0]           ccSel;
logic [2:0]           pcSel;
logic                 stop;
logic [dataWidth-1:0] memData;
logic                 busDone;

debugDecoder decoder (
	.op(op),
	.arg(arg),
	.addrInc(addrInc),
	.addrLd(addrLd),
	.dataSelect(dataSelect),
	.busAction(busAction),
	.regRd(regRd),
	.ccSel(ccSel),
	.pcSel(pcSel),
	.stop(stop)
);

debugCommandPort #(.dataWidth(dataWidth)) commandPort (
	.clk(clk),
	.rstN(rstN),
	.cmdValid(cmdValid),
	.cmdOp(cmdOp),
	.cmdArg(cmdArg),
	.cmdData(cmdData),
	.cmdReady(cmdReady),
	.rspValid(rspValid),
	.rspData(rspData),
	.rspReady(rspReady),
	.op(op),
	.arg(arg),
	.data(data),
	.exec(exec),
	.regRd(regRd),
	.ccSel(ccSel),
	.pcSel(pcSel),
	.stop(stop),
	.dataSelect(dataSelect),
	.busAction(busAction),
	.regRead(regRead),
	.ccReg(ccReg),
	.pcNext(pcNext),
	.cpuStop(cpuStop),
	.regBData(regBData),
	.memData(memData),
	.busDone(busDone)
);

debugBusSequencer #(.dataWidth(dataWidth), .addrWidth(addrWidth)) busSequencer (
	.clk(clk),
	.rstN(rstN),
	.exec(exec),
	.busAction(busAction),
	.addrLd(addrLd),
	.addrInc(addrInc),
	.data(data),
	.memData(memData),
	.busDone(busDone),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbWe(wbWe),
	.wbAdr(wbAdr),
	.wbDatO(wbDatO),
	.wbDatI(wbDatI),
	.wbAck(wbAck)
);

endmodule

`default_nettype wire

/* verilog/debugDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module debugDecoder import debugPkg::*; (
	input  debugOp      op,
	input  logic [3:0]  arg,

	output logic        addrInc,
	output logic        addrLd,
	output dataSel      dataSelect,
	output busSeq       busAction,
	output logic        regRd,
	output logic [1:0]  ccSel,
	output logic [2:0]  pcSel,
	output logic        stop
);

always_comb begin
	// quiet defaults, every case below only overrides.
	addrInc    = 1'b0;
	addrLd     = 1'b0;
	dataSelect = selDin;
	busAction  = busNone;
	regRd      = 1'b0;
	ccSel      = ccRun;
	pcSel      = pcNextNext;
	stop       = 1'b1;

	case (op)
		opNone: begin
			stop = 1'b0; // the only op that lets the cpu run.
		end

		opStop: begin
			stop = 1'b1;
		end

		opRdReg: begin
			regRd      = 1'b1;
			dataSelect = selRegB;
		end

		opRdCc: begin
			ccSel = arg[1:0];
		end

		opRdPc: begin
			pcSel = arg[2:0];
		end

		opRdMem: begin
			busAction  = busRead;
			addrInc    = 1'b1;
			addrLd     = arg[0]; // load address from command data.
			dataSelect = selMem;
		end

		opWrMem: begin
			busAction = busWrite;
			addrInc   = 1'b1;
			addrLd    = arg[0];
		end

		default: begin
			stop = 1'b1; // illegal code halts too.
		end
	endcase
end

endmodule

`default_nettype wire

/* verilog/debugPkg.sv */
`default_nettype none

package debugPkg;

	// host command opcodes. code 7 is illegal and decodes as a halt.
	typedef enum logic [2:0] {
		opNone  = 3'd0,
		opStop  = 3'd1,
		opRdReg = 3'd2,
		opRdCc  = 3'd3,
		opRdPc  = 3'd4,
		opRdMem = 3'd5,
		opWrMem = 3'd6
	} debugOp;

	// source of the response word.
	typedef enum logic [1:0] {
		selDin  = 2'd0, // echo of the command data.
		selRegB = 2'd1,
		selMem  = 2'd2
	} dataSel;

	// memory bus action for the current command.
	typedef enum logic [1:0] {
		busNone  = 2'd0,
		busRead  = 2'd1,
		busWrite = 2'd2
	} busSeq;

	// command port sequence.
	typedef enum logic [1:0] {
		stIdle    = 2'd0,
		stExec    = 2'd1,
		stWaitBus = 2'd2,
		stRespond = 2'd3
	} portState;

	localparam logic [1:0] ccRun      = 2'd0; // condition-code select while running.
	localparam logic [2:0] pcNextNext = 3'd0; // plain pc sequencing.

endpackage

`default_nettype wire
